//--- filelist.f
hw/mipsIsaPkg.sv
hw/decodeCtrlPkg.sv
hw/idReg.sv
hw/regFile.sv
hw/controlDecoder.sv
hw/loadUseHazard.sv
hw/idStage.sv
sim/idStage_props.sv
sim/idStageTb.sv

//--- Bender.yml
package:
  name: id_stage

sources:
  - hw/mipsIsaPkg.sv
  - hw/decodeCtrlPkg.sv
  - hw/idReg.sv
  - hw/regFile.sv
  - hw/controlDecoder.sv
  - hw/loadUseHazard.sv
  - hw/idStage.sv
  - target: simulation
    files:
      - sim/idStage_props.sv
      - sim/idStageTb.sv

//--- sim/idStageTb.sv
module idStageTb import mipsIsaPkg::*, decodeCtrlPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        word       imm;
        aluOp      alu;
        aluSrcA    srcA;
        aluSrcB    srcB;
        logic      regWr;
        dstSel     dst;
        wbSel      wb;
        logic      memRd;
        logic      memWr;
        branchType br;
        logic      jmp;
        rsrtRead   reads;
        logic      illegal;
    } ctrlT;

    logic clk = 1'b0;
    logic arstN, idFlush, idWr, wbRfWr, exeMemRead;
    word ifInstr, ifPc, wbResult;
    regAddr wbDst, exeRt;
    word idInstr, idPc, idBusA, idBusB, idImm32;
    regAddr idRs, idRt, idRd;
    aluOp idAluOp;
    aluSrcA idAluSrcA;
    aluSrcB idAluSrcB;
    logic idRegWr, idMemRead, idMemWrite, idIsImmJump, idIllegal;
    dstSel idDstSel;
    wbSel idWbSel;
    branchType idBranchType;
    rsrtRead idRsrtRead;
    logic dhPcWr, dhIdWr, exeFlushDataHazard;

    // model state of the IF/ID register and the register file
    word mInstr, mPc;
    word shadow [0:31];
    logic [31:0] seed = 32'd36;
    word pcCnt = 32'h0040_0000;
    int errors = 0;
    int timeouts = 0;

    idStage idStage_i (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {seed[15:0], seed[31:16]};   // low LCG bits are weak
    endfunction

    function automatic ctrlT decodeRef(input word instr);
        ctrlT c;
        opcode op;
        funct fn;
        c  = '0;                           // inactive unless the opcode says otherwise
        op = instr[31:26];
        fn = instr[5:0];
        case (op)
            opSpecial: begin
                c.regWr = 1'b1;
                c.reads = 2'b11;
                case (fn)
                    fnAddu: c.alu = aluAdd;
                    fnSubu: c.alu = aluSub;
                    fnAnd:  c.alu = aluAnd;
                    fnOr:   c.alu = aluOr;
                    fnXor:  c.alu = aluXor;
                    fnSlt:  c.alu = aluSlt;
                    fnSll: begin
                        c.alu   = aluSll;
                        c.srcA  = srcAShamt;
                        c.reads = 2'b01;
                        if (instr == '0) begin
                            c.regWr = 1'b0;   // NOP writes and reads nothing
                            c.reads = 2'b00;
                        end
                    end
                    default: begin
                        c.regWr   = 1'b0;
                        c.reads   = 2'b00;
                        c.illegal = 1'b1;
                    end
                endcase
            end
            opAddiu, opAndi, opOri, opLui, opLw: begin
                c.srcB  = srcBImm;
                c.regWr = 1'b1;
                c.dst   = dstRt;
                c.reads = (op == opLui) ? 2'b00 : 2'b10;
                if (op == opAndi) c.alu = aluAnd;
                if (op == opOri) c.alu = aluOr;
                if (op == opLui) c.alu = aluLui;
                if (op == opLw) begin
                    c.wb    = wbMem;
                    c.memRd = 1'b1;
                end
            end
            opSw: begin
                c.srcB  = srcBImm;
                c.memWr = 1'b1;
                c.reads = 2'b11;
            end
            opBeq, opBne: begin
                c.alu   = aluSub;
                c.br    = (op == opBeq) ? brEq : brNe;
                c.reads = 2'b11;
            end
            opJ: c.jmp = 1'b1;
            opJal: begin
                c.jmp   = 1'b1;
                c.regWr = 1'b1;
                c.dst   = dstLink;
                c.wb    = wbPc8;
            end
            default: c.illegal = 1'b1;
        endcase
        if (op == opAndi || op == opOri) c.imm = {16'h0, instr[15:0]};
        else if (op == opLui) c.imm = {instr[15:0], 16'h0};
        else c.imm = {{16{instr[15]}}, instr[15:0]};
        return c;
    endfunction

    function automatic word readModel(input regAddr addr);
        if (addr == '0) return '0;
        if (wbRfWr && wbDst == addr) return wbResult;   // bypass
        return shadow[addr];
    endfunction

    function automatic word randLegal();
        logic [31:0] r;
        int k;
        opcode ops [10] = '{opAddiu, opAndi, opOri, opLui, opLw, opSw,
                            opBeq, opBne, opJ, opJal};
        funct fns [7] = '{fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnSlt, fnSll};
        r = nextRand();
        k = nextRand() % 18;
        if (k < 7) return {opSpecial, r[25:6], fns[k]};
        if (k < 17) return {ops[k-7], r[25:0]};
        return '0;                          // NOP
    endfunction

    function automatic word randIllegal();
        word w;
        ctrlT c;
        w = nextRand();
        c = decodeRef(w);
        while (!c.illegal) begin
            w = nextRand();
            c = decodeRef(w);
        end
        return w;
    endfunction

    task automatic checkEq(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // model of the IF/ID register and of the register-file writes
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mInstr = '0;
            mPc    = resetPc;
            for (int i = 0; i < 32; i++) shadow[i] = '0;
        end else begin
            if (idFlush) begin
                mInstr = '0;
                mPc    = ifPc;
            end else if (idWr) begin
                mInstr = ifInstr;
                mPc    = ifPc;
            end
            if (wbRfWr && wbDst != '0) shadow[wbDst] = wbResult;
        end
    end

    // compare, before the stimulus of this edge takes effect
    always @(negedge clk) begin
        ctrlT e;
        logic hz;
        if (arstN) begin
            e  = decodeRef(mInstr);
            hz = exeMemRead && exeRt != '0 &&
                 ((e.reads[1] && mInstr[25:21] == exeRt) ||
                  (e.reads[0] && mInstr[20:16] == exeRt));
            checkEq("idInstr", idInstr, mInstr);
            checkEq("idPc", idPc, mPc);
            checkEq("idRs", idRs, mInstr[25:21]);
            checkEq("idRt", idRt, mInstr[20:16]);
            checkEq("idRd", idRd, mInstr[15:11]);
            checkEq("idBusA", idBusA, readModel(mInstr[25:21]));
            checkEq("idBusB", idBusB, readModel(mInstr[20:16]));
            checkEq("idImm32", idImm32, e.imm);
            checkEq("idAluOp", idAluOp, e.alu);
            checkEq("idAluSrcA", idAluSrcA, e.srcA);
            checkEq("idAluSrcB", idAluSrcB, e.srcB);
            checkEq("idRegWr", idRegWr, e.regWr);
            checkEq("idDstSel", idDstSel, e.dst);
            checkEq("idWbSel", idWbSel, e.wb);
            checkEq("idMemRead", idMemRead, e.memRd);
            checkEq("idMemWrite", idMemWrite, e.memWr);
            checkEq("idBranchType", idBranchType, e.br);
            checkEq("idIsImmJump", idIsImmJump, e.jmp);
            checkEq("idRsrtRead", idRsrtRead, e.reads);
            checkEq("idIllegal", idIllegal, e.illegal);
            checkEq("dhPcWr", dhPcWr, !hz);
            checkEq("dhIdWr", dhIdWr, !hz);
            checkEq("exeFlushDataHazard", exeFlushDataHazard, hz);
        end
    end

    task automatic waitForInstr(input word exp, input int limit);
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < limit && !seen; i++) begin
            @(negedge clk);
            seen = (idInstr === exp);
        end
        if (!seen) begin
            $display("Timeout: the decode register never took instruction %h", exp);
            timeouts++;
        end
    endtask

    task automatic loadInstr(input word instr);
        @(negedge clk);
        ifInstr <= instr;
        ifPc    <= pcCnt;
        idWr    <= 1'b1;
        pcCnt   += 4;
        waitForInstr(instr, 5);
        idWr    <= 1'b0;
    endtask

    initial begin
        word held, v;
        regAddr a;
        arstN = 1'b0;
        idFlush = 1'b0;
        idWr = 1'b0;
        ifInstr = '0;
        ifPc = '0;
        wbRfWr = 1'b0;
        wbDst = '0;
        wbResult = '0;
        exeRt = '0;
        exeMemRead = 1'b0;
        repeat (4) @(negedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkEq("idPc after reset", idPc, resetPc);

        // register writes, then reads through ADDU
        repeat (24) begin
            @(negedge clk);
            wbRfWr   <= 1'b1;
            wbDst    <= regAddr'(nextRand() % 31 + 1);
            wbResult <= nextRand();
        end
        @(negedge clk);
        wbRfWr <= 1'b0;
        repeat (12) begin
            v = nextRand();
            loadInstr({opSpecial, v[9:0], 10'd0, fnAddu});
        end

        // bypass, checked mid low phase
        repeat (8) begin
            a = regAddr'(nextRand() % 31 + 1);
            v = nextRand();
            loadInstr({opSpecial, a, a, 5'd3, 5'd0, fnAddu});
            wbRfWr   <= 1'b1;
            wbDst    <= a;
            wbResult <= v;
            #2 checkEq("bypass idBusA", idBusA, v);
            checkEq("bypass idBusB", idBusB, v);
        end
        loadInstr({opSpecial, 5'd0, 5'd0, 5'd3, 5'd0, fnAddu});
        wbDst    <= '0;
        wbResult <= nextRand();
        #2 checkEq("r0 read", idBusA, '0);
        @(negedge clk);
        wbRfWr <= 1'b0;

        // decode of legal and illegal encodings
        repeat (160) loadInstr(randLegal());
        repeat (40) loadInstr(randIllegal());

        // load-use hazard
        repeat (40) begin
            held = randLegal();
            loadInstr(held);
            exeMemRead <= 1'b1;
            case (nextRand() % 3)
                0: exeRt <= held[25:21];
                1: exeRt <= held[20:16];
                default: exeRt <= regAddr'(nextRand());
            endcase
            @(negedge clk);
            exeMemRead <= 1'b0;
        end

        // stall holds, flush clears
        held = randLegal() | 32'h0000_0001;   // never a NOP
        loadInstr(held);
        ifInstr <= nextRand();
        ifPc    <= 32'h1234_5678;
        repeat (3) @(negedge clk);
        checkEq("stalled idInstr", idInstr, held);
        idFlush <= 1'b1;
        ifPc    <= 32'h0040_1000;
        waitForInstr('0, 5);
        idFlush <= 1'b0;
        checkEq("flushed idPc", idPc, 32'h0040_1000);

        @(negedge clk);
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- sim/idStage_props.sv
module idStageProps import mipsIsaPkg::*; (
    input logic   clk,
    input logic   arstN,
    input regAddr idRs,
    input word    idBusA,
    input regAddr exeRt,
    input logic   exeMemRead,
    input logic   dhPcWr,
    input logic   dhIdWr,
    input logic   exeFlushDataHazard
);
    timeunit 1ns;
    timeprecision 1ps;

    // bubble into EXE only behind a load to a real register, and it freezes PC and IF/ID
    assert property (@(posedge clk) disable iff (!arstN)
        exeFlushDataHazard |-> (!dhPcWr && !dhIdWr && exeMemRead && (exeRt != '0)))
        else $error("hazard flush without a load or without freeze");

    assert property (@(posedge clk) disable iff (!arstN)
        (idRs == '0) |-> (idBusA == '0))
        else $error("r0 read is not zero");

    // quiet hazard outputs until the first load shows up
    assert property (@(posedge clk)
        $rose(arstN) |-> (dhPcWr && dhIdWr && !exeFlushDataHazard) until exeMemRead)
        else $error("hazard raised before any load");

endmodule

bind idStage idStageProps idStageProps_i (
    .clk                (clk),
    .arstN              (arstN),
    .idRs               (idRs),
    .idBusA             (idBusA),
    .exeRt              (exeRt),
    .exeMemRead         (exeMemRead),
    .dhPcWr             (dhPcWr),
    .dhIdWr             (dhIdWr),
    .exeFlushDataHazard (exeFlushDataHazard)
);

//--- hw/idStage.sv
module idStage import mipsIsaPkg::*, decodeCtrlPkg::*; (
    input  logic      clk,
    input  logic      arstN,
    input  logic      idFlush,
    input  logic      idWr,
    input  word       ifInstr,
    input  word       ifPc,
    input  logic      wbRfWr,
    input  regAddr    wbDst,
    input  word       wbResult,
    input  regAddr    exeRt,
    input  logic      exeMemRead,
    output word       idInstr,
    output word       idPc,
    output regAddr    idRs,
    output regAddr    idRt,
    output regAddr    idRd,
    output word       idBusA,
    output word       idBusB,
    output word       idImm32,
    output aluOp      idAluOp,
    output aluSrcA    idAluSrcA,
    output aluSrcB    idAluSrcB,
    output logic      idRegWr,
    output dstSel     idDstSel,
    output wbSel      idWbSel,
    output logic      idMemRead,
    output logic      idMemWrite,
    output branchType idBranchType,
    output logic      idIsImmJump,
    output rsrtRead   idRsrtRead,
    output logic      idIllegal,
    output logic      dhPcWr,
    output logic      dhIdWr,
    output logic      exeFlushDataHazard
);

    idReg idReg_i (
        .clk     (clk),
        .arstN   (arstN),
        .idFlush (idFlush),
        .idWr    (idWr),
        .ifInstr (ifInstr),
        .ifPc    (ifPc),
        .idInstr (idInstr),
        .idPc    (idPc),
        .idRs    (idRs),
        .idRt    (idRt),
        .idRd    (idRd),
        .idImm16 ()          // decoder extends straight from idInstr
    );

    regFile regFile_i (
        .clk      (clk),
        .arstN    (arstN),
        .wbRfWr   (wbRfWr),
        .wbDst    (wbDst),
        .wbResult (wbResult),
        .idRs     (idRs),
        .idRt     (idRt),
        .idBusA   (idBusA),
        .idBusB   (idBusB)
    );

    controlDecoder controlDecoder_i (
        .idInstr      (idInstr),
        .idImm32      (idImm32),
        .idAluOp      (idAluOp),
        .idAluSrcA    (idAluSrcA),
        .idAluSrcB    (idAluSrcB),
        .idRegWr      (idRegWr),
        .idDstSel     (idDstSel),
        .idWbSel      (idWbSel),
        .idMemRead    (idMemRead),
        .idMemWrite   (idMemWrite),
        .idBranchType (idBranchType),
        .idIsImmJump  (idIsImmJump),
        .idRsrtRead   (idRsrtRead),
        .idIllegal    (idIllegal)
    );

    // hazard outputs go back to the pipeline controller
    loadUseHazard loadUseHazard_i (
        .idRs               (idRs),
        .idRt               (idRt),
        .idRsrtRead         (idRsrtRead),
        .exeRt              (exeRt),
        .exeMemRead         (exeMemRead),
        .dhPcWr             (dhPcWr),
        .dhIdWr             (dhIdWr),
        .exeFlushDataHazard (exeFlushDataHazard)
    );

endmodule

//--- hw/loadUseHazard.sv
module loadUseHazard import mipsIsaPkg::*, decodeCtrlPkg::*; (
    input  regAddr  idRs,
    input  regAddr  idRt,
    input  rsrtRead idRsrtRead,
    input  regAddr  exeRt,
    input  logic    exeMemRead,
    output logic    dhPcWr,
    output logic    dhIdWr,
    output logic    exeFlushDataHazard
);

    logic rsHit;
    logic rtHit;
    logic loadUse;

    // only operands the ID instruction really reads can collide
    assign rsHit = idRsrtRead[rsReadBit] && (idRs == exeRt);
    assign rtHit = idRsrtRead[rtReadBit] && (idRt == exeRt);

    // a load into r0 never produces a value worth waiting for
    assign loadUse = exeMemRead && (exeRt != '0) && (rsHit || rtHit);

    // freeze fetch and decode for one cycle, bubble into EXE
    assign dhPcWr             = !loadUse;
    assign dhIdWr             = !loadUse;
    assign exeFlushDataHazard = loadUse;

endmodule

//--- hw/controlDecoder.sv
module controlDecoder import mipsIsaPkg::*, decodeCtrlPkg::*; (
    input  word       idInstr,
    output word       idImm32,
    output aluOp      idAluOp,
    output aluSrcA    idAluSrcA,
    output aluSrcB    idAluSrcB,
    output logic      idRegWr,
    output dstSel     idDstSel,
    output wbSel      idWbSel,
    output logic      idMemRead,
    output logic      idMemWrite,
    output branchType idBranchType,
    output logic      idIsImmJump,
    output rsrtRead   idRsrtRead,
    output logic      idIllegal
);

    opcode op;
    funct  fn;
    imm16  imm;
    extOp  ext;

    assign op  = idInstr[opMsb:opLsb];
    assign fn  = idInstr[functMsb:functLsb];
    assign imm = idInstr[immMsb:immLsb];

    always_comb begin
        // inactive defaults, also what an illegal encoding sees
        idAluOp      = aluAdd;
        idAluSrcA    = srcARs;
        idAluSrcB    = srcBRt;
        idRegWr      = 1'b0;
        idDstSel     = dstRd;
        idWbSel      = wbAlu;
        idMemRead    = 1'b0;
        idMemWrite   = 1'b0;
        idBranchType = brNone;
        idIsImmJump  = 1'b0;
        idRsrtRead   = '0;
        idIllegal    = 1'b0;
        ext          = extSign;

        unique case (op)
            opSpecial: begin
                idRegWr                = 1'b1;   // all R-type ops write rd
                idRsrtRead[rsReadBit]  = 1'b1;
                idRsrtRead[rtReadBit]  = 1'b1;
                unique case (fn)
                    fnAddu: idAluOp = aluAdd;
                    fnSubu: idAluOp = aluSub;
                    fnAnd:  idAluOp = aluAnd;
                    fnOr:   idAluOp = aluOr;
                    fnXor:  idAluOp = aluXor;
                    fnSlt:  idAluOp = aluSlt;
                    fnSll: begin
                        idAluOp               = aluSll;
                        idAluSrcA             = srcAShamt;
                        idRsrtRead[rsReadBit] = 1'b0;   // shifts rt only
                        if (idInstr == '0) begin
                            // canonical NOP: no write, no operand reads
                            idRegWr    = 1'b0;
                            idRsrtRead = '0;
                        end
                    end
                    default: begin
                        idRegWr    = 1'b0;
                        idRsrtRead = '0;
                        idIllegal  = 1'b1;
                    end
                endcase
            end
            opAddiu, opAndi, opOri: begin
                idAluOp               = (op == opAddiu) ? aluAdd :
                                        (op == opAndi)  ? aluAnd : aluOr;
                idAluSrcB             = srcBImm;
                idRegWr               = 1'b1;
                idDstSel              = dstRt;
                idRsrtRead[rsReadBit] = 1'b1;
                ext                   = (op == opAddiu) ? extSign : extZero;
            end
            opLui: begin
                idAluOp   = aluLui;
                idAluSrcB = srcBImm;
                idRegWr   = 1'b1;
                idDstSel  = dstRt;
                ext       = extHigh;   // no register source
            end
            opLw: begin
                idAluSrcB             = srcBImm;   // base + offset
                idRegWr               = 1'b1;
                idDstSel              = dstRt;
                idWbSel               = wbMem;
                idMemRead             = 1'b1;
                idRsrtRead[rsReadBit] = 1'b1;
            end
            opSw: begin
                idAluSrcB             = srcBImm;
                idMemWrite            = 1'b1;
                idRsrtRead[rsReadBit] = 1'b1;
                idRsrtRead[rtReadBit] = 1'b1;      // store data
            end
            opBeq, opBne: begin
                idAluOp               = aluSub;
                idBranchType          = (op == opBeq) ? brEq : brNe;
                idRsrtRead[rsReadBit] = 1'b1;
                idRsrtRead[rtReadBit] = 1'b1;
            end
            opJ: idIsImmJump = 1'b1;
            opJal: begin
                idIsImmJump = 1'b1;
                idRegWr     = 1'b1;
                idDstSel    = dstLink;
                idWbSel     = wbPc8;
            end
            default: idIllegal = 1'b1;
        endcase
    end

    // immediate extension
    always_comb begin
        unique case (ext)
            extZero: idImm32 = {16'h0000, imm};
            extHigh: idImm32 = {imm, 16'h0000};
            default: idImm32 = {{16{imm[15]}}, imm};
        endcase
    end

endmodule

//--- hw/regFile.sv
module regFile import mipsIsaPkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  logic   wbRfWr,
    input  regAddr wbDst,
    input  word    wbResult,
    input  regAddr idRs,
    input  regAddr idRt,
    output word    idBusA,
    output word    idBusB
);

    word  regs [1:31];   // r0 is not stored
    logic wrEn;

    assign wrEn = wbRfWr && (wbDst != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wbDst] <= wbResult;
        end
    end

    // one read port, with the writeback value passed through on a match
    function automatic word readPort(input regAddr addr);
        word data;
        if (addr == '0) begin
            data = '0;
        end else if (wrEn && (wbDst == addr)) begin
            data = wbResult;        // same-cycle write wins
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    assign idBusA = readPort(idRs);
    assign idBusB = readPort(idRt);

endmodule

//--- hw/idReg.sv
module idReg import mipsIsaPkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  logic   idFlush,
    input  logic   idWr,
    input  word    ifInstr,
    input  word    ifPc,
    output word    idInstr,
    output word    idPc,
    output regAddr idRs,
    output regAddr idRt,
    output regAddr idRd,
    output imm16   idImm16
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idInstr <= '0;        // NOP
            idPc    <= resetPc;
        end else if (idFlush) begin
            // bubble, but keep the PC so the slot still has an address
            idInstr <= '0;
            idPc    <= ifPc;
        end else if (idWr) begin
            idInstr <= ifInstr;
            idPc    <= ifPc;
        end
        // otherwise hold, stall from the pipeline controller
    end

    // field split done once, here
    assign idRs    = idInstr[rsMsb:rsLsb];
    assign idRt    = idInstr[rtMsb:rtLsb];
    assign idRd    = idInstr[rdMsb:rdLsb];
    assign idImm16 = idInstr[immMsb:immLsb];

endmodule

//--- hw/decodeCtrlPkg.sv
package decodeCtrlPkg;

    localparam int aluOpW = 4;
    localparam int selW   = 2;   // width of the multi-way selects

    // bit positions inside rsrtRead
    localparam int rsReadBit = 1;
    localparam int rtReadBit = 0;

    typedef enum logic [aluOpW-1:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluXor = 4'd4,
        aluSlt = 4'd5,
        aluSll = 4'd6,
        aluLui = 4'd7    // passes the shifted immediate
    } aluOp;

    typedef enum logic { srcARs = 1'b0, srcAShamt = 1'b1 } aluSrcA;

    typedef enum logic { srcBRt = 1'b0, srcBImm = 1'b1 } aluSrcB;

    typedef enum logic [selW-1:0] {
        dstRd   = 2'd0,
        dstRt   = 2'd1,
        dstLink = 2'd2   // r31 for JAL
    } dstSel;

    typedef enum logic [selW-1:0] {
        wbAlu = 2'd0,
        wbMem = 2'd1,
        wbPc8 = 2'd2     // return address
    } wbSel;

    typedef enum logic [selW-1:0] { brNone = 2'd0, brEq = 2'd1, brNe = 2'd2 } branchType;

    // immediate extension modes
    typedef enum logic [selW-1:0] { extSign = 2'd0, extZero = 2'd1, extHigh = 2'd2 } extOp;

    typedef logic [1:0] rsrtRead;

endpackage

//--- hw/mipsIsaPkg.sv
package mipsIsaPkg;

    // widths fixed by the ISA
    typedef logic [31:0] word;      // data, address or instruction
    typedef logic [4:0]  regAddr;   // register index
    typedef logic [15:0] imm16;     // raw immediate field
    typedef logic [5:0]  opcode;
    typedef logic [5:0]  funct;

    // field positions within an instruction word
    localparam int opMsb    = 31;
    localparam int opLsb    = 26;
    localparam int rsMsb    = 25;
    localparam int rsLsb    = 21;
    localparam int rtMsb    = 20;
    localparam int rtLsb    = 16;
    localparam int rdMsb    = 15;
    localparam int rdLsb    = 11;
    localparam int shamtMsb = 10;
    localparam int shamtLsb = 6;
    localparam int functMsb = 5;
    localparam int functLsb = 0;
    localparam int immMsb   = 15;
    localparam int immLsb   = 0;

    // primary opcodes of the supported subset
    localparam opcode opSpecial = 6'h00;  // R-type, funct selects the op
    localparam opcode opJ       = 6'h02;
    localparam opcode opJal     = 6'h03;
    localparam opcode opBeq     = 6'h04;
    localparam opcode opBne     = 6'h05;
    localparam opcode opAddiu   = 6'h09;
    localparam opcode opAndi    = 6'h0c;
    localparam opcode opOri     = 6'h0d;
    localparam opcode opLui     = 6'h0f;
    localparam opcode opLw      = 6'h23;
    localparam opcode opSw      = 6'h2b;

    // funct codes under SPECIAL
    localparam funct fnSll  = 6'h00;
    localparam funct fnAddu = 6'h21;
    localparam funct fnSubu = 6'h23;
    localparam funct fnAnd  = 6'h24;
    localparam funct fnOr   = 6'h25;
    localparam funct fnXor  = 6'h26;
    localparam funct fnSlt  = 6'h2a;

    // JAL writes its return address here
    localparam regAddr regLink = 5'd31;

    // boot vector, kseg1 uncached
    localparam word resetPc = 32'hbfc0_0000;

endpackage
